/* sim/back_end_cases.txt */
# unit op dest src0 src1 imm_valid imm expected
# unit 0 is the ALU and 1 the multiplier, first six columns decimal, imm and expected hex
0 0 10 1 2 0 00000000 03030303
0 1 11 5 0 1 00000105 05050400
0 5 13 4 0 1 00000004 40404040
0 7 14 0 0 1 80000000 00000000
1 0 15 2 3 0 00000000 18120c06
0 3 16 7 8 0 00000000 0f0f0f0f
0 2 17 7 0 1 0000ffff 00000707
0 0 20 10 11 0 00000000 08080703
0 0 21 20 0 1 00000010 08080713
1 0 22 21 0 1 00000002 10100e26
0 1 23 22 21 0 00000000 08080713
0 1 25 0 0 1 00000003 fffffffd
1 1 26 25 23 0 00000000 ffffffff
1 2 27 25 23 0 00000000 08080712
1 0 28 27 0 1 00000010 80807120
1 0 29 1 2 0 00000000 08060402
1 0 30 29 0 1 00000002 100c0804
1 0 31 30 0 1 00000100 0c080400
1 2 18 31 0 1 00000100 0000000c
1 1 19 26 0 1 ffffffff 00000000
1 0 9 28 0 1 00000010 08071200

/* flist.f */
common/backend_pkg.sv
design/issue_stage.sv
execute/alu_unit.sv
execute/mul_unit.sv
rob/reorder_buffer.sv
design/back_end_top.sv
sim/tb_clock.sv
sim/back_end_chk.sv
sim/back_end_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := back_end_tb
FLIST     := flist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/back_end_tb.sv */
module back_end_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import backend_pkg::*;

    logic             clk_i;
    logic             rst_n_i;
    logic             issue_valid_i;
    issue_packet_t    issue_i;
    data_word_t [1:0] operand_i;
    data_word_t       imm_i;
    logic             stall_o;
    logic             writeback_o;
    writeback_t       writeback_data_o;

    // Cases in program order, as read from the file
    issue_packet_t    case_pkt [$];
    data_word_t       case_imm [$];
    data_word_t       case_exp [$];

    // Accepted instructions waiting for their writeback, oldest first
    writeback_t       exp_q [$];
    // Architectural register file as the environment sees it
    data_word_t       regs [32];

    int               seed           = 86684;
    int               errors         = 0;
    int               retired        = 0;
    int               cycle_cnt      = 0;
    int               timeout_cycles = 200;
    logic             stall_s        = 1'b0;
    logic             stall_seen     = 1'b0;
    logic             first_taken    = 1'b0;

    tb_clock u_clock (
        .clk_o ( clk_i )
    );

    back_end_top dut_i (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .issue_valid_i    ( issue_valid_i    ),
        .issue_i          ( issue_i          ),
        .operand_i        ( operand_i        ),
        .imm_i            ( imm_i            ),
        .stall_o          ( stall_o          ),
        .writeback_o      ( writeback_o      ),
        .writeback_data_o ( writeback_data_o )
    );

    bind back_end_top back_end_chk u_chk (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .stall_i          ( stall_o          ),
        .writeback_i      ( writeback_o      ),
        .writeback_data_i ( writeback_data_o )
    );

    // ============================================================
    // Helpers
    // ============================================================

    // Each line holds unit, op, dest, src0, src1, imm_valid, imm and the expected result
    task automatic load_cases(output bit ok);
        int            fd;
        int            n;
        string         line;
        int            f [6];
        data_word_t    imm_v;
        data_word_t    exp_v;
        issue_packet_t pkt;
        ok = 1'b0;
        fd = $fopen("sim/back_end_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], imm_v, exp_v);
                    if (n == 8) begin
                        pkt      = '0;
                        pkt.unit = f[0][0];
                        // The same uop word is filled through the view of its unit
                        if (f[0][0]) begin
                            pkt.uop.mul.op = mul_op_t'(f[1][1:0]);
                        end else begin
                            pkt.uop.alu.op = alu_op_t'(f[1][2:0]);
                        end
                        pkt.reg_dest   = reg_addr_t'(f[2]);
                        pkt.reg_src[0] = reg_addr_t'(f[3]);
                        pkt.reg_src[1] = reg_addr_t'(f[4]);
                        pkt.imm_valid  = f[5][0];
                        case_pkt.push_back(pkt);
                        case_imm.push_back(imm_v);
                        case_exp.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
            ok = (case_pkt.size() > 0);
        end
    endtask

    // Register file read for the offered sources, possibly older than the buffer
    task automatic drive_operands(input issue_packet_t pkt);
        operand_i[0] <= regs[pkt.reg_src[0]];
        operand_i[1] <= regs[pkt.reg_src[1]];
    endtask

    task automatic check_writeback();
        writeback_t expected;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Writeback of r%0d seen with no instruction outstanding",
                     writeback_data_o.reg_dest);
        end else begin
            expected = exp_q.pop_front();
            retired++;
            if (writeback_data_o != expected) begin
                errors++;
                $display("ERROR at %0t: writeback %0d gave r%0d = %h, expected r%0d = %h",
                         $time, retired, writeback_data_o.reg_dest, writeback_data_o.result,
                         expected.reg_dest, expected.result);
            end
        end
        regs[writeback_data_o.reg_dest] = writeback_data_o.result;
    endtask

    // ============================================================
    // Monitor and watchdog
    // ============================================================

    // Outputs are settled at the falling edge
    always @(negedge clk_i) begin : monitor
        if (!rst_n_i) begin
            // The model register file starts over with every reset
            for (int i = 0; i < 32; i++) begin
                regs[i] = data_word_t'(i) * 32'h0101_0101;
            end
        end else begin
            stall_s = stall_o;
            if (stall_o) begin
                stall_seen = 1'b1;
            end
            if (!first_taken && (stall_o || writeback_o)) begin
                errors++;
                $display("ERROR at %0t: stall_o or writeback_o high before the first issue",
                         $time);
            end
            if (writeback_o) begin
                check_writeback();
            end
        end
    end : monitor

    always @(posedge clk_i) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d writebacks still missing",
                     cycle_cnt, exp_q.size());
            $display("sim failed");
            $finish;
        end
    end : watchdog

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin : driver
        bit         ok;
        int         gap;
        logic       prev_mul;
        int         end_errors;
        int         assert_fails;
        writeback_t next_exp;

        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        operand_i     = '0;
        imm_i         = '0;
        end_errors    = 0;
        prev_mul      = 1'b0;

        load_cases(ok);
        if (!ok) begin
            $display("No case could be read from sim/back_end_cases.txt");
            $display("sim failed");
            $finish;
        end else begin
            timeout_cycles = case_pkt.size() * 8 + 200;
            repeat (10) @(posedge clk_i);
            rst_n_i <= 1'b1;
            @(posedge clk_i);

            foreach (case_pkt[c]) begin
                // ALU cases get idle gaps except right after a multiply, so they finish first
                // Multiplies never get a gap and arrive as one burst
                gap = 0;
                if (!case_pkt[c].unit && !prev_mul) begin
                    gap = int'($unsigned($random(seed)) % 4);
                end
                prev_mul = case_pkt[c].unit;
                repeat (gap) begin
                    issue_valid_i <= 1'b0;
                    @(posedge clk_i);
                end
                issue_valid_i <= 1'b1;
                issue_i       <= case_pkt[c];
                imm_i         <= case_imm[c];
                drive_operands(case_pkt[c]);
                @(posedge clk_i);
                // Held while stalled, but the register file read follows retirement
                while (stall_s) begin
                    drive_operands(case_pkt[c]);
                    @(posedge clk_i);
                end
                first_taken       = 1'b1;
                next_exp.reg_dest = case_pkt[c].reg_dest;
                next_exp.result   = case_exp[c];
                exp_q.push_back(next_exp);
            end
            issue_valid_i <= 1'b0;

            // Drain the buffer, then leave room for a stray extra writeback
            while (exp_q.size() != 0) begin
                @(posedge clk_i);
            end
            repeat (8) @(posedge clk_i);

            if (!stall_seen) begin
                end_errors++;
                $display("stall_o never went high during the dependent and burst cases");
            end
            assert_fails = int'(dut_i.u_chk.fail_count);

            $display("Retired %0d of %0d, %0d check errors, %0d end errors, %0d assertion fails",
                     retired, case_pkt.size(), errors, end_errors, assert_fails);
            if (errors + end_errors + assert_fails == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end : driver

endmodule : back_end_tb

/* sim/back_end_chk.sv */
module back_end_chk (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    stall_i,
    input logic                    writeback_i,
    input backend_pkg::writeback_t writeback_data_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // ============================================================
    // Port properties of the back end
    // ============================================================

    // Nothing can retire in the cycle right after reset release
    wb_quiet_after_reset : assert property (@(posedge clk_i) $rose(rst_n_i) |-> !writeback_i)
        else begin
            fail_count++;
            $error("writeback_o high in the first cycle after reset");
        end

    // An empty buffer has no pending source and is never full
    stall_low_after_reset : assert property (@(posedge clk_i) $rose(rst_n_i) |-> !stall_i)
        else begin
            fail_count++;
            $error("stall_o high in the first cycle after reset");
        end

    // Retired data must be fully known
    wb_data_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                     writeback_i |-> !$isunknown(writeback_data_i))
        else begin
            fail_count++;
            $error("writeback_data_o has unknown bits while writeback_o is high");
        end

endmodule : back_end_chk

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Free running 8 ns clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

endmodule : tb_clock

/* design/back_end_top.sv */
module back_end_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          issue_valid_i,
    input  backend_pkg::issue_packet_t    issue_i,
    input  backend_pkg::data_word_t [1:0] operand_i,
    input  backend_pkg::data_word_t       imm_i,
    output logic                          stall_o,
    output logic                          writeback_o,
    output backend_pkg::writeback_t       writeback_data_o
);

    import backend_pkg::*;

    fwd_lookup_t [1:0] fwd;
    logic              rob_full;
    rob_tag_t          alloc_tag;
    logic              alloc;
    logic              alu_valid;
    logic              mul_valid;
    exec_packet_t      exec_pkt;
    result_packet_t    alu_result;
    result_packet_t    mul_result;

    // ============================================================
    // Issue
    // ============================================================

    issue_stage u_issue (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .issue_valid_i ( issue_valid_i ),
        .issue_i       ( issue_i       ),
        .operand_i     ( operand_i     ),
        .imm_i         ( imm_i         ),
        .fwd_i         ( fwd           ),
        .rob_full_i    ( rob_full      ),
        .alloc_tag_i   ( alloc_tag     ),
        .stall_o       ( stall_o       ),
        .alloc_o       ( alloc         ),
        .alu_valid_o   ( alu_valid     ),
        .mul_valid_o   ( mul_valid     ),
        .exec_o        ( exec_pkt      )
    );

    // ============================================================
    // Execution units
    // ============================================================

    alu_unit u_alu (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .valid_i  ( alu_valid  ),
        .exec_i   ( exec_pkt   ),
        .result_o ( alu_result )
    );

    mul_unit u_mul (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .valid_i  ( mul_valid  ),
        .exec_i   ( exec_pkt   ),
        .result_o ( mul_result )
    );

    // ============================================================
    // Reorder buffer
    // ============================================================

    // Sources and destination of the offered instruction feed the lookup and allocation
    reorder_buffer u_rob (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .alloc_i          ( alloc            ),
        .alloc_dest_i     ( issue_i.reg_dest ),
        .alloc_tag_o      ( alloc_tag        ),
        .full_o           ( rob_full         ),
        .alu_result_i     ( alu_result       ),
        .mul_result_i     ( mul_result       ),
        .lookup_src_i     ( issue_i.reg_src  ),
        .fwd_o            ( fwd              ),
        .writeback_o      ( writeback_o      ),
        .writeback_data_o ( writeback_data_o )
    );

endmodule : back_end_top

/* rob/reorder_buffer.sv */
module reorder_buffer (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           alloc_i,
    input  backend_pkg::reg_addr_t         alloc_dest_i,
    output backend_pkg::rob_tag_t          alloc_tag_o,
    output logic                           full_o,
    input  backend_pkg::result_packet_t    alu_result_i,
    input  backend_pkg::result_packet_t    mul_result_i,
    input  backend_pkg::reg_addr_t [1:0]   lookup_src_i,
    output backend_pkg::fwd_lookup_t [1:0] fwd_o,
    output logic                           writeback_o,
    output backend_pkg::writeback_t        writeback_data_o
);

    import backend_pkg::*;

    rob_tag_t             head_q;
    rob_tag_t             tail_q;
    logic [TAG_W:0]       count_q;
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;
    writeback_t           entry_q [ROB_DEPTH];
    logic                 retire;

    // ============================================================
    // Status and retirement
    // ============================================================

    // New instructions always land at the tail
    assign alloc_tag_o = tail_q;
    assign full_o      = (count_q == (TAG_W+1)'(ROB_DEPTH));

    // Head leaves as soon as its result is in, retirement never waits
    assign retire           = valid_q[head_q] & done_q[head_q];
    assign writeback_o      = retire;
    assign writeback_data_o = entry_q[head_q];

    always_ff @(posedge clk_i) begin : ctrl_reg
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            // Both units may complete in the same cycle, always to different tags
            if (alu_result_i.valid) begin
                done_q[alu_result_i.tag] <= 1'b1;
            end
            if (mul_result_i.valid) begin
                done_q[mul_result_i.tag] <= 1'b1;
            end
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            // Tail never equals a valid head here since allocation waits while full
            if (alloc_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            case ({alloc_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end : ctrl_reg

    // Destination is known at allocation, the result arrives with completion
    always_ff @(posedge clk_i) begin : entry_reg
        if (alloc_i) begin
            entry_q[tail_q].reg_dest <= alloc_dest_i;
        end
        if (alu_result_i.valid) begin
            entry_q[alu_result_i.tag].result <= alu_result_i.result;
        end
        if (mul_result_i.valid) begin
            entry_q[mul_result_i.tag].result <= mul_result_i.result;
        end
    end : entry_reg

    // ============================================================
    // Forwarding lookup
    // ============================================================

    // Walk from the head toward the tail so the youngest match is the one kept
    always_comb begin : lookup
        rob_tag_t idx;
        for (int s = 0; s < 2; s++) begin
            fwd_o[s] = '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                idx = head_q + rob_tag_t'(i);
                if (valid_q[idx] && (entry_q[idx].reg_dest == lookup_src_i[s])) begin
                    fwd_o[s].hit     = done_q[idx];
                    fwd_o[s].pending = ~done_q[idx];
                    fwd_o[s].data    = entry_q[idx].result;
                end
            end
        end
    end : lookup

endmodule : reorder_buffer

/* execute/mul_unit.sv */
module mul_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  backend_pkg::exec_packet_t   exec_i,
    output backend_pkg::result_packet_t result_o
);

    import backend_pkg::*;

    // Control that rides alongside the data through every stage
    typedef struct packed {
        rob_tag_t  tag;
        reg_addr_t reg_dest;
        mul_op_t   op;
    } mul_ctrl_t;

    logic [MUL_STAGES-1:0] valid_q;
    mul_ctrl_t             ctrl_q [MUL_STAGES];

    data_word_t            opa_q;
    data_word_t            opb_q;
    logic                  sign_ext;
    logic signed [63:0]    full_product;
    logic [63:0]           product_q;
    data_word_t            result_q;

    // ============================================================
    // Control pipeline
    // ============================================================

    always_ff @(posedge clk_i) begin : valid_pipe
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_STAGES-2:0], valid_i};
        end
    end : valid_pipe

    always_ff @(posedge clk_i) begin : ctrl_pipe
        ctrl_q[0] <= '{tag: exec_i.tag, reg_dest: exec_i.reg_dest, op: exec_i.uop.mul.op};
        for (int k = 1; k < MUL_STAGES; k++) begin
            ctrl_q[k] <= ctrl_q[k-1];
        end
    end : ctrl_pipe

    // ============================================================
    // Data pipeline
    // ============================================================

    // Only the signed high product treats the operands as two's complement
    assign sign_ext = (ctrl_q[0].op == MUL_HIGH_S);

    // Low 64 bits of the 33 bit extended product are exact for both signed and unsigned
    assign full_product = $signed({sign_ext & opa_q[XLEN-1], opa_q})
                        * $signed({sign_ext & opb_q[XLEN-1], opb_q});

    always_ff @(posedge clk_i) begin : data_pipe
        // Stage 1 captures the operands
        opa_q     <= exec_i.operand[0];
        opb_q     <= exec_i.operand[1];
        // Stage 2 holds the full product
        product_q <= full_product;
        // Stage 3 picks the half that was asked for
        if (ctrl_q[1].op == MUL_LOW) begin
            result_q <= product_q[XLEN-1:0];
        end else begin
            result_q <= product_q[63:XLEN];
        end
    end : data_pipe

    assign result_o = '{valid:    valid_q[MUL_STAGES-1],
                        tag:      ctrl_q[MUL_STAGES-1].tag,
                        reg_dest: ctrl_q[MUL_STAGES-1].reg_dest,
                        result:   result_q};

endmodule : mul_unit

/* execute/alu_unit.sv */
module alu_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  backend_pkg::exec_packet_t   exec_i,
    output backend_pkg::result_packet_t result_o
);

    import backend_pkg::*;

    data_word_t opa;
    data_word_t opb;
    data_word_t alu_result;
    logic       valid_q;
    rob_tag_t   tag_q;
    reg_addr_t  dest_q;
    data_word_t result_q;

    assign opa = exec_i.operand[0];
    assign opb = exec_i.operand[1];

    // The ALU view of the micro-op word selects the operation
    always_comb begin : compute
        case (exec_i.uop.alu.op)
            ALU_ADD: alu_result = opa + opb;
            ALU_SUB: alu_result = opa - opb;
            ALU_AND: alu_result = opa & opb;
            ALU_OR:  alu_result = opa | opb;
            ALU_XOR: alu_result = opa ^ opb;
            // Shift amount is the low 5 bits of the second operand
            ALU_SLL: alu_result = opa << opb[4:0];
            ALU_SRL: alu_result = opa >> opb[4:0];
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            default: alu_result = opa + opb;
        endcase
    end : compute

    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end : valid_reg

    // Tag and destination follow the result into the buffer
    always_ff @(posedge clk_i) begin : result_reg
        tag_q    <= exec_i.tag;
        dest_q   <= exec_i.reg_dest;
        result_q <= alu_result;
    end : result_reg

    assign result_o = '{valid: valid_q, tag: tag_q, reg_dest: dest_q, result: result_q};

endmodule : alu_unit

/* design/issue_stage.sv */
module issue_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           issue_valid_i,
    input  backend_pkg::issue_packet_t     issue_i,
    input  backend_pkg::data_word_t [1:0]  operand_i,
    input  backend_pkg::data_word_t        imm_i,
    input  backend_pkg::fwd_lookup_t [1:0] fwd_i,
    input  logic                           rob_full_i,
    input  backend_pkg::rob_tag_t          alloc_tag_i,
    output logic                           stall_o,
    output logic                           alloc_o,
    output logic                           alu_valid_o,
    output logic                           mul_valid_o,
    output backend_pkg::exec_packet_t      exec_o
);

    import backend_pkg::*;

    data_word_t [1:0] operand_sel;
    logic             src0_wait;
    logic             src1_wait;
    logic             accept;

    // ============================================================
    // Operand resolution
    // ============================================================

    // A completed but unretired producer overrides the register file value
    assign operand_sel[0] = fwd_i[0].hit ? fwd_i[0].data : operand_i[0];

    // Source 1 may be replaced by the immediate, in which case its lookup is ignored
    always_comb begin : src1_select
        if (issue_i.imm_valid) begin
            operand_sel[1] = imm_i;
        end else if (fwd_i[1].hit) begin
            operand_sel[1] = fwd_i[1].data;
        end else begin
            operand_sel[1] = operand_i[1];
        end
    end : src1_select

    // ============================================================
    // Stall and acceptance
    // ============================================================

    // A producer that has not completed yet blocks the consumer
    assign src0_wait = fwd_i[0].pending;
    assign src1_wait = fwd_i[1].pending & ~issue_i.imm_valid;

    // Computed whether or not an instruction is offered
    assign stall_o = rob_full_i | src0_wait | src1_wait;

    assign accept  = issue_valid_i & ~stall_o;

    // The buffer takes the tail entry at the same edge the instruction is accepted
    assign alloc_o = accept;

    // ============================================================
    // Issue register
    // ============================================================

    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            mul_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= accept & ~issue_i.unit;
            mul_valid_o <= accept & issue_i.unit;
        end
    end : valid_reg

    // Payload only moves on acceptance, the strobes qualify it
    always_ff @(posedge clk_i) begin : exec_reg
        if (accept) begin
            exec_o.uop      <= issue_i.uop;
            exec_o.operand  <= operand_sel;
            exec_o.tag      <= alloc_tag_i;
            exec_o.reg_dest <= issue_i.reg_dest;
        end
    end : exec_reg

endmodule : issue_stage

/* common/backend_pkg.sv */
package backend_pkg;

    // ============================================================
    // Widths and sizes
    // ============================================================

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_DEPTH  = 8;
    localparam int TAG_W      = 3;
    localparam int MUL_STAGES = 3;

    typedef logic [XLEN-1:0]       data_word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      rob_tag_t;

    // ============================================================
    // Micro-op encodings
    // ============================================================

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // Low half, signed high half, unsigned high half
    typedef enum logic [1:0] {
        MUL_LOW    = 2'd0,
        MUL_HIGH_S = 2'd1,
        MUL_HIGH_U = 2'd2
    } mul_op_t;

    typedef struct packed {
        logic    pad;
        alu_op_t op;
    } alu_uop_t;

    typedef struct packed {
        logic [1:0] pad;
        mul_op_t    op;
    } mul_uop_t;

    // One 4 bit word, read through the view that matches the unit select
    typedef union packed {
        alu_uop_t alu;
        mul_uop_t mul;
    } exu_uop_t;

    // ============================================================
    // Packets between the stages
    // ============================================================

    // Instruction as offered by the environment, unit 1 selects the multiplier
    typedef struct packed {
        logic                 unit;
        exu_uop_t             uop;
        reg_addr_t            reg_dest;
        reg_addr_t [1:0]      reg_src;
        logic                 imm_valid;
    } issue_packet_t;

    typedef struct packed {
        exu_uop_t        uop;
        data_word_t [1:0] operand;
        rob_tag_t        tag;
        reg_addr_t       reg_dest;
    } exec_packet_t;

    typedef struct packed {
        logic       valid;
        rob_tag_t   tag;
        reg_addr_t  reg_dest;
        data_word_t result;
    } result_packet_t;

    typedef struct packed {
        logic       hit;
        logic       pending;
        data_word_t data;
    } fwd_lookup_t;

    typedef struct packed {
        reg_addr_t  reg_dest;
        data_word_t result;
    } writeback_t;

endpackage : backend_pkg
